// File: Makefile
# Verilator build for the core_lite project

VERILATOR ?= verilator
FILELIST  ?= core_lite.f
TB_TOP    ?= core_tb
RTL_TOP   ?= core_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

# exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: core_lite.f
+incdir+hdl
hdl/core_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/pipe_control.sv
hdl/exec_stage.sv
hdl/core_top.sv
dv/tb_clock_gen.sv
dv/core_tb.sv

// File: dv/core_tb.sv
`timescale 1ns/1ps

`include "core_config.svh"

module core_tb
  import core_pkg::*;
();

  localparam logic [31:0] LFSR_SEED     = 32'hcb1f78b1;
  // taps of x^32 + x^22 + x^2 + x + 1 in right-shifting form
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;
  localparam int          RESET_TIMEOUT = 100;
  localparam int          DRAIN_TIMEOUT = 50;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  instr_u      instr;
  wb_t         wb;

  logic [31:0] lfsr;
  data_t       model_regs [`NUM_REGS];
  wb_t         exp_q [$];
  int          due_q [$];
  int          edge_cnt = 0;
  string       test_name = "reset_idle";

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  core_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb)
  );

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
  endfunction

  function automatic reg_addr_t rand_reg();
    logic [31:0] v;
    v = rand_bits(`REG_ADDR_BITS);
    return v[`REG_ADDR_BITS-1:0];
  endfunction

  function automatic reg_addr_t rand_nonzero_reg();
    reg_addr_t r;
    r = rand_reg();
    if (r == '0) begin
      r = reg_addr_t'(1);
    end
    return r;
  endfunction

  function automatic logic [`IMM_WIDTH-1:0] rand_imm();
    logic [31:0] v;
    v = rand_bits(`IMM_WIDTH);
    return v[`IMM_WIDTH-1:0];
  endfunction

  function automatic logic [`SHAMT_BITS-1:0] rand_shamt();
    logic [31:0] v;
    v = rand_bits(`SHAMT_BITS);
    return v[`SHAMT_BITS-1:0];
  endfunction

  function automatic logic coin();
    logic [31:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // instruction words
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [`FUNCT_BITS-1:0] pick_funct(logic [2:0] sel);
    case (sel)
      3'd0:    return `FN_ADD;
      3'd1:    return `FN_SUB;
      3'd2:    return `FN_AND;
      3'd3:    return `FN_OR;
      3'd4:    return `FN_XOR;
      3'd5:    return `FN_SLT;
      3'd6:    return `FN_SLL;
      default: return `FN_SRL;
    endcase
  endfunction

  function automatic logic [`OPCODE_BITS-1:0] pick_iop(logic [2:0] sel);
    case (sel)
      3'd0, 3'd5: return `OP_ADDI;
      3'd1, 3'd6: return `OP_ANDI;
      3'd2, 3'd7: return `OP_ORI;
      3'd3:       return `OP_XORI;
      default:    return `OP_LUI;
    endcase
  endfunction

  // random opcode outside the decoded set
  function automatic logic [`OPCODE_BITS-1:0] unknown_op();
    logic [31:0] v;
    logic [`OPCODE_BITS-1:0] op;
    v  = rand_bits(`OPCODE_BITS);
    op = v[`OPCODE_BITS-1:0];
    if (op inside {`OP_RTYPE, `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI}) begin
      op = 6'h3f;
    end
    return op;
  endfunction

  function automatic logic [`FUNCT_BITS-1:0] unknown_funct();
    logic [31:0] v;
    logic [`FUNCT_BITS-1:0] fn;
    v  = rand_bits(`FUNCT_BITS);
    fn = v[`FUNCT_BITS-1:0];
    if (fn inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLL,
                   `FN_SRL}) begin
      fn = 6'h3f;
    end
    return fn;
  endfunction

  function automatic instr_u make_r(logic [`FUNCT_BITS-1:0] funct, reg_addr_t rs,
                                    reg_addr_t rt, reg_addr_t rd,
                                    logic [`SHAMT_BITS-1:0] shamt);
    instr_u w;
    w.r.opcode = `OP_RTYPE;
    w.r.rs     = rs;
    w.r.rt     = rt;
    w.r.rd     = rd;
    w.r.shamt  = shamt;
    w.r.funct  = funct;
    return w;
  endfunction

  function automatic instr_u make_i(logic [`OPCODE_BITS-1:0] op, reg_addr_t rs,
                                    reg_addr_t rt, logic [`IMM_WIDTH-1:0] imm);
    instr_u w;
    w.i.opcode = op;
    w.i.rs     = rs;
    w.i.rt     = rt;
    w.i.imm    = imm;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////

  // called on the driving edge
  // wb is due WB_LATENCY edges later
  task automatic predict(instr_u w);
    data_t a;
    data_t b;
    data_t imm_z;
    data_t y;
    logic  writes;
    wb_t   e;
    a      = model_regs[w.r.rs];
    b      = model_regs[w.r.rt];
    imm_z  = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, w.i.imm};
    y      = '0;
    writes = 1'b1;
    e.dst  = w.i.rt;
    case (w.r.opcode)
      `OP_RTYPE: begin
        e.dst = w.r.rd;
        case (w.r.funct)
          `FN_ADD: y = a + b;
          `FN_SUB: y = a - b;
          `FN_AND: y = a & b;
          `FN_OR:  y = a | b;
          `FN_XOR: y = a ^ b;
          `FN_SLT: y[0] = $signed(a) < $signed(b);
          `FN_SLL: y = b << w.r.shamt;
          `FN_SRL: y = b >> w.r.shamt;
          default: writes = 1'b0;
        endcase
      end
      `OP_ADDI: y = a + imm_z;
      `OP_ANDI: y = a & imm_z;
      `OP_ORI:  y = a | imm_z;
      `OP_XORI: y = a ^ imm_z;
      `OP_LUI:  y = {w.i.imm, {(`DATA_WIDTH-`IMM_WIDTH){1'b0}}};
      default:  writes = 1'b0;
    endcase
    if (writes) begin
      e.valid = 1'b1;
      e.data  = y;
      exp_q.push_back(e);
      due_q.push_back(edge_cnt + 1 + `WB_LATENCY);
      // r0 write is still reported on wb
      if (e.dst != '0) begin
        model_regs[e.dst] = y;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_wb(string name, wb_t exp, wb_t act);
    if (act !== exp) begin
      fail_run($sformatf("FAILED %s: expected dst %0d data 0x%08h, actual dst %0d data 0x%08h",
                         name, exp.dst, exp.data, act.dst, act.data));
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      fail_run($sformatf("FAILED %s: expected wb.valid %b, actual %b at edge %0d",
                         name, exp, act, edge_cnt));
    end
  endtask

  // wb sampled mid-cycle
  always @(negedge clk) begin : watch_wb
    logic pulse_due;
    wb_t  exp;
    pulse_due = 1'b0;
    if (due_q.size() != 0) begin
      pulse_due = (due_q[0] == edge_cnt);
    end
    check_valid(test_name, pulse_due, wb.valid);
    if (pulse_due) begin
      exp = exp_q.pop_front();
      void'(due_q.pop_front());
      check_wb(test_name, exp, wb);
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////////////////

  task automatic issue(instr_u w);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= w;
    predict(w);
  endtask

  // garbage on instr while the strobe is low
  task automatic bubble();
    @(posedge clk);
    instr_valid <= 1'b0;
    instr       <= instr_u'(rand_bits(`INST_WIDTH));
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (!rst_n && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      fail_run("timeout: reset was never released");
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    bubble();
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      bubble();
      waited++;
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("timeout: %0d write-backs never arrived in test %s",
                         exp_q.size(), test_name));
    end
    repeat (`WB_LATENCY) bubble();
  endtask

  ////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    reg_addr_t   x;
    reg_addr_t   y;
    logic [31:0] sel;
    lfsr        = LFSR_SEED;
    instr_valid = 1'b0;
    instr       = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = '0;
    end

    wait_reset();
    repeat (20) bubble();
    drain();

    // full random word in every register
    // ori reads its lui result at distance 1
    test_name = "itype";
    for (int r = 1; r < `NUM_REGS; r++) begin
      x = reg_addr_t'(r);
      issue(make_i(`OP_LUI, rand_reg(), x, rand_imm()));
      issue(make_i(`OP_ORI, x, x, rand_imm()));
    end
    for (int n = 0; n < 200; n++) begin
      sel = rand_bits(3);
      issue(make_i(pick_iop(sel[2:0]), rand_reg(), rand_reg(), rand_imm()));
    end
    drain();

    test_name = "rtype";
    for (int n = 0; n < 300; n++) begin
      sel = rand_bits(3);
      issue(make_r(pick_funct(sel[2:0]), rand_reg(), rand_reg(), rand_reg(), rand_shamt()));
    end
    drain();

    // producer of x and d-1 fillers that never write x
    // then a consumer of x
    test_name = "forwarding";
    for (int d = 1; d <= 3; d++) begin
      for (int n = 0; n < 40; n++) begin
        x = rand_nonzero_reg();
        y = x + reg_addr_t'(1);
        if (y == '0) begin
          y = reg_addr_t'(1);
        end
        issue(make_i(`OP_ADDI, rand_reg(), x, rand_imm()));
        for (int f = 1; f < d; f++) begin
          if (coin()) begin
            bubble();
          end else begin
            issue(make_i(`OP_XORI, x, y, rand_imm()));
          end
        end
        sel = rand_bits(3);
        issue(make_r(pick_funct(sel[2:0]), x, coin() ? x : rand_reg(), x, rand_shamt()));
        sel = rand_bits(2);
        if (sel[1:0] == 2'd0) begin
          bubble();
        end
      end
    end
    drain();

    test_name = "non_writing";
    for (int n = 0; n < 80; n++) begin
      sel = rand_bits(2);
      case (sel[1:0])
        2'd0: issue(make_i(unknown_op(), rand_reg(), rand_reg(), rand_imm()));
        2'd1: issue(make_r(unknown_funct(), rand_reg(), rand_reg(), rand_reg(), rand_shamt()));
        2'd2: bubble();
        default: begin
          // r0 write followed by readers at distance 1 and 2
          issue(make_i(`OP_ORI, rand_reg(), '0, rand_imm()));
          issue(make_r(`FN_OR, '0, rand_reg(), rand_nonzero_reg(), '0));
          issue(make_r(`FN_ADD, '0, '0, rand_nonzero_reg(), '0));
        end
      endcase
    end
    drain();

    $display("Simulation passed");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam time HALF_PERIOD  = 10ns;
  localparam int  RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

  // release on a rising edge, after the flops have seen it low
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

`include "core_config.svh"

module alu
  import core_pkg::*;
(
  input  alu_op_e                op,
  input  data_t                  a,
  input  data_t                  b,
  input  logic [`SHAMT_BITS-1:0] shamt,
  output data_t                  result
);

  logic lt_signed;

  assign lt_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      // 1 or 0, two's complement compare
      ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
      // shifts act on the rt operand
      ALU_SLL: result = b << shamt;
      ALU_SRL: result = b >> shamt;
      // immediate into the upper half
      ALU_LUI: result = b << `IMM_WIDTH;
      default: result = '0;
    endcase
  end

endmodule

// File: hdl/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// architectural widths
`define DATA_WIDTH     32
`define INST_WIDTH     32
`define REG_ADDR_BITS  5
`define NUM_REGS       32
`define IMM_WIDTH      16
`define SHAMT_BITS     5
`define OPCODE_BITS    6
`define FUNCT_BITS     6

// opcodes
`define OP_RTYPE       6'h00
`define OP_ADDI        6'h08
`define OP_ANDI        6'h0c
`define OP_ORI         6'h0d
`define OP_XORI        6'h0e
`define OP_LUI         6'h0f

// funct codes, R-type only
`define FN_SLL         6'h00
`define FN_SRL         6'h02
`define FN_ADD         6'h20
`define FN_SUB         6'h22
`define FN_AND         6'h24
`define FN_OR          6'h25
`define FN_XOR         6'h26
`define FN_SLT         6'h2a

// issue edge to visible write-back
`define WB_LATENCY     3

`endif

// File: hdl/core_pkg.sv
`include "core_config.svh"

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // basic words
  //////////////////////////////////////////////////////////////////////

  typedef logic [`DATA_WIDTH-1:0]    data_t;
  typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // instruction word
  //////////////////////////////////////////////////////////////////////

  // register-register format
  typedef struct packed {
    logic [`OPCODE_BITS-1:0] opcode;
    reg_addr_t               rs;
    reg_addr_t               rt;
    reg_addr_t               rd;
    logic [`SHAMT_BITS-1:0]  shamt;
    logic [`FUNCT_BITS-1:0]  funct;
  } r_fields_t;

  // register-immediate format, rt is the destination
  typedef struct packed {
    logic [`OPCODE_BITS-1:0] opcode;
    reg_addr_t               rs;
    reg_addr_t               rt;
    logic [`IMM_WIDTH-1:0]   imm;
  } i_fields_t;

  // same 32 bits, two field layouts
  typedef union packed {
    r_fields_t               r;
    i_fields_t               i;
    logic [`INST_WIDTH-1:0]  raw;
  } instr_u;

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_e;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      imm_src;    // operand b from the immediate
    logic      reg_write;
    reg_addr_t dst;
  } ctrl_t;

  // what execute needs of one instruction
  typedef struct packed {
    ctrl_t                  ctrl;
    reg_addr_t              rs;
    reg_addr_t              rt;
    logic [`SHAMT_BITS-1:0] shamt;
  } ex_ctrl_t;

  // write-back bus, also the register file write port
  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    data_t     data;
  } wb_t;

endpackage

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   instr_valid,
  input  instr_u instr,
  output wb_t    wb
);

  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     imm;
  logic      ex_capture;
  ex_ctrl_t  ex_ctrl;
  logic      fwd_a;
  logic      fwd_b;
  logic      wb_valid;
  reg_addr_t wb_dst;
  data_t     rd_a;
  data_t     rd_b;
  data_t     result;

  pipe_control i_pipe_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .imm         (imm),
    .ex_capture  (ex_capture),
    .ex_ctrl     (ex_ctrl),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .wb_valid    (wb_valid),
    .wb_dst      (wb_dst)
  );

  // write-back also feeds the register file write port
  reg_file i_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .wb      (wb),
    .rd_a    (rd_a),
    .rd_b    (rd_b)
  );

  exec_stage i_exec_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_capture (ex_capture),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .imm        (imm),
    .ex_ctrl    (ex_ctrl),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .result     (result)
  );

  assign wb = '{valid: wb_valid, dst: wb_dst, data: result};

endmodule

// File: hdl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_capture,
  input  data_t    rd_a,
  input  data_t    rd_b,
  input  data_t    imm,
  input  ex_ctrl_t ex_ctrl,
  input  logic     fwd_a,
  input  logic     fwd_b,
  output data_t    result
);

  data_t opa_q;
  data_t opb_q;
  data_t imm_q;
  data_t result_q;
  data_t alu_a;
  data_t opb_fwd;
  data_t alu_b;
  data_t alu_y;

  ////////////////////////////////////////////////////////////////////////
  // operand registers
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      opa_q <= '0;
      opb_q <= '0;
      imm_q <= '0;
    end else if (ex_capture) begin
      opa_q <= rd_a;
      opb_q <= rd_b;
      imm_q <= imm;
    end
  end

  // forwarding first, then immediate select
  always_comb begin
    alu_a   = fwd_a ? result_q : opa_q;
    opb_fwd = fwd_b ? result_q : opb_q;
    alu_b   = ex_ctrl.ctrl.imm_src ? imm_q : opb_fwd;
  end

  alu i_alu (
    .op     (ex_ctrl.ctrl.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .shamt  (ex_ctrl.shamt),
    .result (alu_y)
  );

  ////////////////////////////////////////////////////////////////////////
  // result register, the write-back stage data
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_q <= '0;
    end else begin
      result_q <= alu_y;
    end
  end

  assign result = result_q;

endmodule

// File: hdl/pipe_control.sv
`timescale 1ns/1ps

`include "core_config.svh"

module pipe_control
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      instr_valid,
  input  instr_u    instr,
  output reg_addr_t rs_addr,
  output reg_addr_t rt_addr,
  output data_t     imm,
  output logic      ex_capture,
  output ex_ctrl_t  ex_ctrl,
  output logic      fwd_a,
  output logic      fwd_b,
  output logic      wb_valid,
  output reg_addr_t wb_dst
);

  logic      dec_valid;
  instr_u    dec_instr;
  ctrl_t     dec_ctrl;
  logic      ex_valid;
  ex_ctrl_t  ex_q;
  logic      wb_valid_q;
  reg_addr_t wb_dst_q;

  ////////////////////////////////////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      dec_instr <= '0;
    end else begin
      dec_valid <= instr_valid;
      if (instr_valid) begin
        dec_instr <= instr;
      end
    end
  end

  // unknown opcode or funct leaves reg_write low
  always_comb begin
    dec_ctrl.alu_op    = ALU_ADD;
    dec_ctrl.imm_src   = 1'b0;
    dec_ctrl.reg_write = 1'b0;
    dec_ctrl.dst       = dec_instr.r.rd;
    case (dec_instr.r.opcode)
      `OP_RTYPE: begin
        dec_ctrl.reg_write = 1'b1;
        case (dec_instr.r.funct)
          `FN_ADD: dec_ctrl.alu_op = ALU_ADD;
          `FN_SUB: dec_ctrl.alu_op = ALU_SUB;
          `FN_AND: dec_ctrl.alu_op = ALU_AND;
          `FN_OR:  dec_ctrl.alu_op = ALU_OR;
          `FN_XOR: dec_ctrl.alu_op = ALU_XOR;
          `FN_SLT: dec_ctrl.alu_op = ALU_SLT;
          `FN_SLL: dec_ctrl.alu_op = ALU_SLL;
          `FN_SRL: dec_ctrl.alu_op = ALU_SRL;
          default: dec_ctrl.reg_write = 1'b0;
        endcase
      end
      `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
        dec_ctrl.imm_src   = 1'b1;
        dec_ctrl.reg_write = 1'b1;
        dec_ctrl.dst       = dec_instr.i.rt;
        case (dec_instr.i.opcode)
          `OP_ANDI: dec_ctrl.alu_op = ALU_AND;
          `OP_ORI:  dec_ctrl.alu_op = ALU_OR;
          `OP_XORI: dec_ctrl.alu_op = ALU_XOR;
          `OP_LUI:  dec_ctrl.alu_op = ALU_LUI;
          default:  dec_ctrl.alu_op = ALU_ADD;
        endcase
      end
      default: dec_ctrl.reg_write = 1'b0;
    endcase
  end

  assign rs_addr    = dec_instr.r.rs;
  assign rt_addr    = dec_instr.r.rt;
  // zero-extended for every I-type op
  assign imm        = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, dec_instr.i.imm};
  assign ex_capture = dec_valid;

  ////////////////////////////////////////////////////////////////////////
  // execute and write-back stages
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid   <= 1'b0;
      ex_q       <= '0;
      wb_valid_q <= 1'b0;
      wb_dst_q   <= '0;
    end else begin
      ex_valid <= dec_valid;
      if (dec_valid) begin
        ex_q.ctrl  <= dec_ctrl;
        ex_q.rs    <= dec_instr.r.rs;
        ex_q.rt    <= dec_instr.r.rt;
        ex_q.shamt <= dec_instr.r.shamt;
      end
      // bubbles and non-writing ops drop out here
      wb_valid_q <= ex_valid & ex_q.ctrl.reg_write;
      wb_dst_q   <= ex_q.ctrl.dst;
    end
  end

  assign ex_ctrl  = ex_q;
  assign wb_valid = wb_valid_q;
  assign wb_dst   = wb_dst_q;

  // result register holds the next older instruction
  // r0 is never forwarded, it reads as zero
  assign fwd_a = wb_valid_q && (wb_dst_q != '0) && (wb_dst_q == ex_q.rs);
  assign fwd_b = wb_valid_q && (wb_dst_q != '0) && (wb_dst_q == ex_q.rt);

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

`include "core_config.svh"

module reg_file
  import core_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs_addr,
  input  reg_addr_t rt_addr,
  input  wb_t       wb,
  output data_t     rd_a,
  output data_t     rd_b
);

  data_t regs [`NUM_REGS];

  // r0 is zero, a write in flight wins over the stored word
  function automatic data_t read_port(reg_addr_t addr);
    data_t word;
    if (addr == '0) begin
      word = '0;
    end else if (wb.valid && (wb.dst == addr)) begin
      word = wb.data;
    end else begin
      word = regs[addr];
    end
    return word;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.dst != '0)) begin
      regs[wb.dst] <= wb.data;
    end
  end

  always_comb begin
    rd_a = read_port(rs_addr);
    rd_b = read_port(rt_addr);
  end

endmodule
